// File: l1d_pkg.sv
/* Cache geometry, request opcodes and the address, word, line and tag types
   shared by the L1 data cache */
package l1d_pkg;

	// --------------------
	// Geometry
	localparam int WAY_NUM    = 2;
	localparam int SET_NUM    = 16;
	localparam int LINE_BYTES = 16;
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int OFFSET_W   = 4;
	localparam int IDX_W      = 4;
	localparam int TAG_W      = ADDR_W - IDX_W - OFFSET_W;

	// --------------------
	// Scalar types
	typedef logic [ADDR_W-1:0]       addr_t;
	typedef logic [DATA_W-1:0]       word_t;
	typedef logic [LINE_BYTES*8-1:0] line_t;
	typedef logic [DATA_W/8-1:0]     be_t;
	typedef logic [TAG_W-1:0]        tag_t;
	typedef logic [IDX_W-1:0]        idx_t;
	typedef logic [OFFSET_W-1:0]     offset_t;

	// Byte count of an access, only 1, 2 and 4 are legal
	typedef logic [2:0] size_t;

	// --------------------
	// Core request opcodes
	typedef enum logic [1:0] {
		COP_RD   = 2'd0,
		COP_WR   = 2'd1,
		COP_RDNC = 2'd2,
		COP_WRNC = 2'd3
	} cop_e;

endpackage

// File: l1d_req_if.sv
/* Decoded core request passed from decode to the controller and result stage */
interface l1d_req_if;

	// One-cycle strobe, the fields stay stable until the next request
	logic              val;
	l1d_pkg::cop_e     cop;
	l1d_pkg::tag_t     tag;
	l1d_pkg::idx_t     idx;
	l1d_pkg::offset_t  offset;
	l1d_pkg::word_t    wdata;
	l1d_pkg::be_t      be;
	l1d_pkg::addr_t    addr;

	modport decode (
		output val, cop, tag, idx, offset, wdata, be, addr
	);

	modport exec (
		input val, cop, tag, idx, offset, wdata, be, addr
	);

	modport result (
		input val, offset, cop
	);

endinterface

// File: l1d_req_decode.sv
/* Request decode stage: registers an accepted core request, splits the
   address and builds the byte enables */
module l1d_req_decode (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             core_req_val,
	input  logic             core_req_ready,
	input  l1d_pkg::addr_t   core_req_addr,
	input  l1d_pkg::cop_e    core_req_cop,
	input  l1d_pkg::word_t   core_req_wdata,
	input  l1d_pkg::size_t   core_req_size,
	l1d_req_if.decode        req
);

	logic            accept;
	l1d_pkg::be_t    be_mask;
	l1d_pkg::addr_t  addr_q;

	assign accept = core_req_val & core_req_ready;

	// Mask for the access size, then moved to its byte lane
	always_comb begin
		case (core_req_size)
			3'd1:    be_mask = 4'b0001;
			3'd2:    be_mask = 4'b0011;
			default: be_mask = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req.val <= 1'b0;
		end else begin
			req.val <= accept;
		end
	end

	// Write data arrives already placed in its byte lanes
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q    <= core_req_addr;
			req.cop   <= core_req_cop;
			req.wdata <= core_req_wdata;
			req.be    <= be_mask << core_req_addr[1:0];
		end
	end

	assign req.addr = addr_q;
	assign {req.tag, req.idx, req.offset} = addr_q;

endmodule

// File: l1d_sram.sv
/* Synchronous single-port array with registered read, generic entry type */
module l1d_sram #(
	parameter type entry_t = logic,
	parameter int  DEPTH   = 16
) (
	input  logic                     clk,
	input  logic                     ren,
	input  logic [$clog2(DEPTH)-1:0] raddr,
	output entry_t                   rdata,
	input  logic                     wen,
	input  logic [$clog2(DEPTH)-1:0] waddr,
	input  entry_t                   wdata
);

	entry_t mem [DEPTH];

	// Whole entry is replaced on a write
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// Data appears the cycle after ren
	always_ff @(posedge clk) begin
		if (ren) begin
			rdata <= mem[raddr];
		end
	end

endmodule

// File: l1d_ctrl.sv
/* Cache controller: valid and LRU state, hit detection, line refill,
   write-through and uncached paths */
module l1d_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	l1d_req_if.exec                           req,
	output logic                              core_req_ready,
	output logic [l1d_pkg::WAY_NUM-1:0]       tag_ren,
	output logic [l1d_pkg::WAY_NUM-1:0]       data_ren,
	output l1d_pkg::idx_t                     arr_idx,
	output logic [l1d_pkg::WAY_NUM-1:0]       tag_wen,
	output logic [l1d_pkg::WAY_NUM-1:0]       data_wen,
	output l1d_pkg::tag_t                     tag_wdata,
	output l1d_pkg::line_t                    data_wdata,
	input  l1d_pkg::tag_t                     tag_rdata [l1d_pkg::WAY_NUM],
	input  l1d_pkg::line_t                    data_rdata [l1d_pkg::WAY_NUM],
	output logic                              mem_req_val,
	output logic                              mem_req_we,
	output logic                              mem_req_nc,
	output l1d_pkg::addr_t                    mem_req_addr,
	output l1d_pkg::word_t                    mem_req_wdata,
	output l1d_pkg::be_t                      mem_req_be,
	input  logic                              mem_ack,
	input  l1d_pkg::line_t                    mem_ack_data,
	output logic                              done,
	output l1d_pkg::line_t                    done_line,
	output logic                              done_rd
);

	typedef enum logic [1:0] {IDLE, LOOKUP, MEM_WAIT, FILL} state_e;

	state_e                                        state_q, state_d;
	logic [l1d_pkg::SET_NUM-1:0][l1d_pkg::WAY_NUM-1:0] valid_q;
	// Per set, the way to replace next
	logic [l1d_pkg::SET_NUM-1:0]                   lru_q;
	logic                                          done_q;
	logic                                          victim_q, victim;
	l1d_pkg::line_t                                fill_line_q, merged_line;
	logic                                          is_wr, is_nc, hit, hit_way;
	logic                                          lru_upd, lru_way;

	assign is_wr = (req.cop == l1d_pkg::COP_WR) || (req.cop == l1d_pkg::COP_WRNC);
	assign is_nc = (req.cop == l1d_pkg::COP_RDNC) || (req.cop == l1d_pkg::COP_WRNC);

	// Ready stays low through the ack cycle
	assign core_req_ready = (state_q == IDLE) & ~req.val & ~done_q;

	// --------------------
	// Arrays and lookup
	assign tag_ren   = {l1d_pkg::WAY_NUM{req.val & ~is_nc}};
	assign data_ren  = {l1d_pkg::WAY_NUM{req.val & ~is_nc}};
	assign arr_idx   = req.idx;
	assign tag_wdata = req.tag;

	always_comb begin
		hit     = 1'b0;
		hit_way = 1'b0;
		victim  = lru_q[req.idx];
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (valid_q[req.idx][w] && tag_rdata[w] == req.tag && !is_nc) begin
				hit     = 1'b1;
				hit_way = w[0];
			end
		end
		// First invalid way wins over the LRU way
		for (int w = l1d_pkg::WAY_NUM - 1; w >= 0; w--) begin
			if (!valid_q[req.idx][w]) victim = w[0];
		end
	end

	// Store bytes merged into the hit line
	always_comb begin
		merged_line = data_rdata[hit_way];
		for (int b = 0; b < l1d_pkg::DATA_W / 8; b++) begin
			if (req.be[b]) merged_line[req.offset[3:2]*32 + b*8 +: 8] = req.wdata[b*8 +: 8];
		end
	end

	// --------------------
	// Memory side
	assign mem_req_we    = is_wr;
	assign mem_req_nc    = is_nc;
	assign mem_req_addr  = (is_wr || is_nc) ? req.addr
	                                        : {req.tag, req.idx, {l1d_pkg::OFFSET_W{1'b0}}};
	assign mem_req_wdata = req.wdata;
	assign mem_req_be    = req.be;

	// --------------------
	// FSM
	always_comb begin
		state_d     = state_q;
		tag_wen     = '0;
		data_wen    = '0;
		data_wdata  = fill_line_q;
		mem_req_val = 1'b0;
		done        = 1'b0;
		done_line   = mem_ack_data;
		done_rd     = ~is_wr;
		lru_upd     = 1'b0;
		lru_way     = hit_way;
		case (state_q)
			IDLE: if (req.val) state_d = LOOKUP;
			LOOKUP: begin
				if (hit && !is_wr) begin
					done      = 1'b1;
					done_line = data_rdata[hit_way];
					lru_upd   = 1'b1;
					state_d   = IDLE;
				end else begin
					mem_req_val = 1'b1;
					state_d     = MEM_WAIT;
					if (hit) begin
						data_wen[hit_way] = 1'b1;
						data_wdata        = merged_line;
						lru_upd           = 1'b1;
					end
				end
			end
			MEM_WAIT: begin
				if (mem_ack) begin
					if (!is_wr && !is_nc) begin
						state_d = FILL;
					end else begin
						done    = 1'b1;
						state_d = IDLE;
					end
				end
			end
			FILL: begin
				tag_wen[victim_q]  = 1'b1;
				data_wen[victim_q] = 1'b1;
				done               = 1'b1;
				done_line          = fill_line_q;
				lru_upd            = 1'b1;
				lru_way            = victim_q;
				state_d            = IDLE;
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			valid_q <= '0;
			lru_q   <= '0;
			done_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			done_q  <= done;
			// Two ways, so the other one becomes LRU
			if (lru_upd) lru_q[req.idx] <= ~lru_way;
			if (state_q == FILL) valid_q[req.idx][victim_q] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == LOOKUP) victim_q <= victim;
		if (mem_ack) fill_line_q <= mem_ack_data;
	end

endmodule

// File: l1d_resp.sv
/* Result stage: picks the requested word out of a line and registers the ack */
module l1d_resp (
	input  logic            clk,
	input  logic            rst_n,
	l1d_req_if.result       req,
	input  logic            done,
	input  l1d_pkg::line_t  done_line,
	input  logic            done_rd,
	output logic            core_ack,
	output l1d_pkg::word_t  core_ack_data
);

	l1d_pkg::offset_t  offset_q;
	logic              rd_q;

	// Offset and read flag of the request in flight
	always_ff @(posedge clk) begin
		if (req.val) begin
			offset_q <= req.offset;
			rd_q     <= (req.cop == l1d_pkg::COP_RD) || (req.cop == l1d_pkg::COP_RDNC);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			core_ack <= 1'b0;
		end else begin
			core_ack <= done;
		end
	end

	// Aligned word at the request offset, zero for writes
	always_ff @(posedge clk) begin
		if (done) begin
			if (done_rd && rd_q) begin
				core_ack_data <= done_line[offset_q[l1d_pkg::OFFSET_W-1:2]*l1d_pkg::DATA_W
				                           +: l1d_pkg::DATA_W];
			end else begin
				core_ack_data <= '0;
			end
		end
	end

endmodule

// File: l1d_top.sv
/* L1 data cache top: decode, controller, tag and data ways, result stage */
module l1d_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            core_req_val,
	input  l1d_pkg::addr_t  core_req_addr,
	input  logic [1:0]      core_req_cop,
	input  l1d_pkg::word_t  core_req_wdata,
	input  l1d_pkg::size_t  core_req_size,
	output logic            core_req_ready,
	output logic            core_ack,
	output l1d_pkg::word_t  core_ack_data,
	output logic            mem_req_val,
	output logic            mem_req_we,
	output logic            mem_req_nc,
	output l1d_pkg::addr_t  mem_req_addr,
	output l1d_pkg::word_t  mem_req_wdata,
	output l1d_pkg::be_t    mem_req_be,
	input  logic            mem_ack,
	input  l1d_pkg::line_t  mem_ack_data
);

	logic [l1d_pkg::WAY_NUM-1:0]  tag_ren, data_ren, tag_wen, data_wen;
	l1d_pkg::idx_t                arr_idx;
	l1d_pkg::tag_t                tag_wdata;
	l1d_pkg::line_t               data_wdata;
	l1d_pkg::tag_t                tag_rdata [l1d_pkg::WAY_NUM];
	l1d_pkg::line_t               data_rdata [l1d_pkg::WAY_NUM];
	logic                         done, done_rd;
	l1d_pkg::line_t               done_line;

	l1d_req_if req_if ();

	l1d_req_decode u_decode (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_req_val   (core_req_val),
		.core_req_ready (core_req_ready),
		.core_req_addr  (core_req_addr),
		.core_req_cop   (l1d_pkg::cop_e'(core_req_cop)),
		.core_req_wdata (core_req_wdata),
		.core_req_size  (core_req_size),
		.req            (req_if.decode)
	);

	l1d_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.req            (req_if.exec),
		.core_req_ready (core_req_ready),
		.tag_ren        (tag_ren),
		.data_ren       (data_ren),
		.arr_idx        (arr_idx),
		.tag_wen        (tag_wen),
		.data_wen       (data_wen),
		.tag_wdata      (tag_wdata),
		.data_wdata     (data_wdata),
		.tag_rdata      (tag_rdata),
		.data_rdata     (data_rdata),
		.mem_req_val    (mem_req_val),
		.mem_req_we     (mem_req_we),
		.mem_req_nc     (mem_req_nc),
		.mem_req_addr   (mem_req_addr),
		.mem_req_wdata  (mem_req_wdata),
		.mem_req_be     (mem_req_be),
		.mem_ack        (mem_ack),
		.mem_ack_data   (mem_ack_data),
		.done           (done),
		.done_line      (done_line),
		.done_rd        (done_rd)
	);

	// --------------------
	// Tag and data ways
	for (genvar w = 0; w < l1d_pkg::WAY_NUM; w++) begin : g_way
		l1d_sram #(
			.entry_t (l1d_pkg::tag_t),
			.DEPTH   (l1d_pkg::SET_NUM)
		) u_tag (
			.clk   (clk),
			.ren   (tag_ren[w]),
			.raddr (arr_idx),
			.rdata (tag_rdata[w]),
			.wen   (tag_wen[w]),
			.waddr (arr_idx),
			.wdata (tag_wdata)
		);

		l1d_sram #(
			.entry_t (l1d_pkg::line_t),
			.DEPTH   (l1d_pkg::SET_NUM)
		) u_data (
			.clk   (clk),
			.ren   (data_ren[w]),
			.raddr (arr_idx),
			.rdata (data_rdata[w]),
			.wen   (data_wen[w]),
			.waddr (arr_idx),
			.wdata (data_wdata)
		);
	end

	l1d_resp u_resp (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req_if.result),
		.done          (done),
		.done_line     (done_line),
		.done_rd       (done_rd),
		.core_ack      (core_ack),
		.core_ack_data (core_ack_data)
	);

endmodule

// File: l1d_props.sv
/* Concurrent assertions on the cache controller and their bind into l1d_ctrl */
module l1d_props (
	input logic clk,
	input logic rst_n,
	input logic in_lookup,
	input logic in_wait,
	input logic req_val,
	input logic hit,
	input logic is_wr,
	input logic mem_req_val,
	input logic done,
	input logic core_req_ready
);

	// At most one memory request outstanding
	ap_no_req_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		in_wait |-> !mem_req_val)
		else $error("memory request issued while waiting for memory");

	ap_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done held for more than one cycle");

	// Still low once the decoded strobe has dropped and the lookup runs
	ap_ready_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
		req_val |=> !core_req_ready)
		else $error("core_req_ready high while the accepted request is in lookup");

	ap_no_mem_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
		(in_lookup && hit && !is_wr) |-> !mem_req_val)
		else $error("memory request issued on a read hit");

endmodule

bind l1d_ctrl l1d_props u_props (
	.clk            (clk),
	.rst_n          (rst_n),
	.in_lookup      (state_q == LOOKUP),
	.in_wait        (state_q == MEM_WAIT),
	.req_val        (req.val),
	.hit            (hit),
	.is_wr          (is_wr),
	.mem_req_val    (mem_req_val),
	.done           (done),
	.core_req_ready (core_req_ready)
);

// File: tb_l1d.sv
/* Testbench for the L1 data cache: memory model, reference cache model,
   directed and random stimulus, compare process */
module tb_l1d;

	localparam int TIMEOUT = 200;

	logic              clk;
	logic              rst_n;
	logic              core_req_val;
	l1d_pkg::addr_t    core_req_addr;
	logic [1:0]        core_req_cop;
	l1d_pkg::word_t    core_req_wdata;
	l1d_pkg::size_t    core_req_size;
	logic              core_req_ready;
	logic              core_ack;
	l1d_pkg::word_t    core_ack_data;
	logic              mem_req_val;
	logic              mem_req_we;
	logic              mem_req_nc;
	l1d_pkg::addr_t    mem_req_addr;
	l1d_pkg::word_t    mem_req_wdata;
	l1d_pkg::be_t      mem_req_be;
	logic              mem_ack;
	l1d_pkg::line_t    mem_ack_data;

	// Memory model state and the last request it saw
	l1d_pkg::word_t    mem_words [l1d_pkg::addr_t];
	int                mem_cnt;
	l1d_pkg::addr_t    mem_last_addr;
	l1d_pkg::be_t      mem_last_be;
	bit                mem_last_nc;
	bit                mem_last_we;
	l1d_pkg::word_t    mem_last_wdata;

	// Reference model: shadow memory plus expected tags, valid and LRU
	l1d_pkg::word_t    shadow [l1d_pkg::addr_t];
	bit                ref_valid [l1d_pkg::SET_NUM][l1d_pkg::WAY_NUM];
	l1d_pkg::tag_t     ref_tag [l1d_pkg::SET_NUM][l1d_pkg::WAY_NUM];
	bit                ref_lru [l1d_pkg::SET_NUM];

	// Expected results, one entry per request in flight
	string             q_name [$];
	l1d_pkg::word_t    q_data [$];
	l1d_pkg::addr_t    q_addr [$];
	l1d_pkg::be_t      q_be [$];
	l1d_pkg::word_t    q_wd [$];
	bit                q_mem [$];
	bit                q_wr [$];
	bit                q_nc [$];
	int                q_cnt [$];

	int                chk_cnt, err_cnt, chk_base, err_base;

	l1d_top uut (.*);

	always #10 clk = ~clk;

	// --------------------
	// Memory and reference helpers
	function automatic l1d_pkg::word_t fill_word(l1d_pkg::addr_t wa);
		return wa ^ {wa[15:0], wa[31:16]} ^ 32'h5ac3_0f96;
	endfunction

	function automatic l1d_pkg::be_t size_mask(l1d_pkg::size_t sz);
		case (sz)
			3'd1:    return 4'b0001;
			3'd2:    return 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic l1d_pkg::word_t mem_read(l1d_pkg::addr_t a);
		l1d_pkg::addr_t wa;
		wa = {a[31:2], 2'b00};
		return mem_words.exists(wa) ? mem_words[wa] : fill_word(wa);
	endfunction

	function automatic void mem_write(l1d_pkg::addr_t a, l1d_pkg::word_t d, l1d_pkg::be_t be);
		l1d_pkg::word_t cur;
		cur = mem_read(a);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) cur[b*8 +: 8] = d[b*8 +: 8];
		end
		mem_words[{a[31:2], 2'b00}] = cur;
	endfunction

	// Expected read data, the aligned word holding the address
	function automatic l1d_pkg::word_t ref_read(l1d_pkg::addr_t a);
		l1d_pkg::addr_t wa;
		wa = {a[31:2], 2'b00};
		return shadow.exists(wa) ? shadow[wa] : fill_word(wa);
	endfunction

	function automatic void shadow_write(l1d_pkg::addr_t a, l1d_pkg::word_t d, l1d_pkg::be_t be);
		l1d_pkg::word_t cur;
		cur = ref_read(a);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) cur[b*8 +: 8] = d[b*8 +: 8];
		end
		shadow[{a[31:2], 2'b00}] = cur;
	endfunction

	function automatic bit ref_lookup(l1d_pkg::idx_t i, l1d_pkg::tag_t t, output bit way);
		way = ref_lru[i];
		for (int w = 0; w < l1d_pkg::WAY_NUM; w++) begin
			if (ref_valid[i][w] && ref_tag[i][w] == t) begin
				way = w[0];
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// First invalid way, else the LRU way
	function automatic bit ref_victim(l1d_pkg::idx_t i);
		if (!ref_valid[i][0]) return 1'b0;
		if (!ref_valid[i][1]) return 1'b1;
		return ref_lru[i];
	endfunction

	// --------------------
	// Compare tasks
	task automatic check_word(string name, l1d_pkg::word_t exp, l1d_pkg::word_t act);
		chk_cnt++;
		if (act !== exp) begin
			$display("[FAIL] %s: expected data %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_addr(string name, l1d_pkg::addr_t exp, l1d_pkg::addr_t act);
		chk_cnt++;
		if (act !== exp) begin
			$display("[FAIL] %s: expected memory address %h, actual %h", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_be(string name, l1d_pkg::be_t exp, l1d_pkg::be_t act);
		chk_cnt++;
		if (act !== exp) begin
			$display("[FAIL] %s: expected byte enables %b, actual %b", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_mem_access(string name, bit exp, bit act);
		chk_cnt++;
		if (act !== exp) begin
			$display("[FAIL] %s: expected memory request %0d, actual %0d", name, exp, act);
			err_cnt++;
		end
	endtask

	task automatic report_timeout(string what);
		$display("timeout: no %s within %0d cycles", what, TIMEOUT);
		$display("** FAIL **");
		$finish;
	endtask

	// --------------------
	// Memory model, answers after 1 to 6 cycles
	always @(negedge clk) begin : mem_model
		int unsigned     dly;
		l1d_pkg::line_t  ln;
		if (rst_n && mem_req_val) begin
			mem_cnt++;
			mem_last_addr  = mem_req_addr;
			mem_last_be    = mem_req_be;
			mem_last_nc    = mem_req_nc;
			mem_last_we    = mem_req_we;
			mem_last_wdata = mem_req_wdata;
			if (mem_req_we) mem_write(mem_req_addr, mem_req_wdata, mem_req_be);
			for (int i = 0; i < 4; i++) begin
				ln[i*32 +: 32] = mem_read({mem_req_addr[31:4], 4'h0} + l1d_pkg::addr_t'(i * 4));
			end
			dly = $urandom_range(1, 6);
			repeat (dly) @(negedge clk);
			mem_ack      = 1'b1;
			mem_ack_data = ln;
			@(negedge clk);
			mem_ack = 1'b0;
		end
	end

	// Compare process, one entry per ack
	always @(negedge clk) begin : compare_acks
		string nm;
		if (rst_n && core_ack) begin
			if (q_name.size() == 0) begin
				$display("core_ack arrived with no request outstanding");
				err_cnt++;
			end else begin
				nm = q_name.pop_front();
				check_word(nm, q_data.pop_front(), core_ack_data);
				check_mem_access(nm, q_mem[0], mem_cnt != q_cnt.pop_front());
				if (q_mem[0]) begin
					check_addr(nm, q_addr[0], mem_last_addr);
					check_mem_access({nm, " nc"}, q_nc[0], mem_last_nc);
					check_mem_access({nm, " we"}, q_wr[0], mem_last_we);
					if (q_wr[0]) begin
						check_be(nm, q_be[0], mem_last_be);
						check_word({nm, " wdata"}, q_wd[0], mem_last_wdata);
					end
				end
				void'(q_mem.pop_front());
				void'(q_addr.pop_front());
				void'(q_nc.pop_front());
				void'(q_wr.pop_front());
				void'(q_be.pop_front());
				void'(q_wd.pop_front());
			end
		end
	end

	// --------------------
	// Stimulus
	task automatic access(string name, l1d_pkg::cop_e cop, l1d_pkg::addr_t a,
	                      l1d_pkg::size_t sz, l1d_pkg::word_t wd);
		l1d_pkg::idx_t  idx;
		l1d_pkg::tag_t  tag;
		l1d_pkg::be_t   be;
		bit             way;
		bit             hit;
		int             tmo;
		idx = a[7:4];
		tag = a[31:8];
		be  = size_mask(sz) << a[1:0];
		hit = ref_lookup(idx, tag, way);
		q_name.push_back(name);
		q_cnt.push_back(mem_cnt);
		q_be.push_back(be);
		q_wd.push_back(wd);
		q_wr.push_back(cop == l1d_pkg::COP_WR || cop == l1d_pkg::COP_WRNC);
		q_nc.push_back(cop == l1d_pkg::COP_RDNC || cop == l1d_pkg::COP_WRNC);
		case (cop)
			l1d_pkg::COP_RD: begin
				q_data.push_back(ref_read(a));
				q_mem.push_back(!hit);
				q_addr.push_back({a[31:4], 4'h0});
				if (!hit) begin
					way = ref_victim(idx);
					ref_valid[idx][way] = 1'b1;
					ref_tag[idx][way]   = tag;
				end
				ref_lru[idx] = ~way;
			end
			l1d_pkg::COP_WR: begin
				shadow_write(a, wd, be);
				q_data.push_back('0);
				q_mem.push_back(1'b1);
				q_addr.push_back(a);
				if (hit) ref_lru[idx] = ~way;
			end
			l1d_pkg::COP_RDNC: begin
				q_data.push_back(ref_read(a));
				q_mem.push_back(1'b1);
				q_addr.push_back(a);
			end
			default: begin
				shadow_write(a, wd, be);
				q_data.push_back('0);
				q_mem.push_back(1'b1);
				q_addr.push_back(a);
			end
		endcase
		tmo = 0;
		while (!core_req_ready) begin
			@(negedge clk);
			tmo++;
			if (tmo > TIMEOUT) report_timeout("core_req_ready");
		end
		core_req_val   = 1'b1;
		core_req_addr  = a;
		core_req_cop   = cop;
		core_req_wdata = wd;
		core_req_size  = sz;
		@(negedge clk);
		core_req_val = 1'b0;
		tmo = 0;
		while (!core_ack) begin
			@(negedge clk);
			tmo++;
			if (tmo > TIMEOUT) report_timeout("core_ack");
		end
	endtask

	task automatic finish_test(string name);
		int tmo;
		tmo = 0;
		while (q_name.size() != 0) begin
			@(negedge clk);
			tmo++;
			if (tmo > TIMEOUT) report_timeout("result for the last request");
		end
		$display("test %s: %0d checks, %0d errors", name, chk_cnt - chk_base, err_cnt - err_base);
		chk_base = chk_cnt;
		err_base = err_cnt;
	endtask

	// Cached lines over few sets, uncached traffic at 0x8000_0000
	task automatic random_mix();
		l1d_pkg::cop_e   cop;
		l1d_pkg::size_t  sz;
		l1d_pkg::addr_t  a;
		int unsigned     sel, boff;
		for (int n = 0; n < 300; n++) begin
			sel = $urandom_range(0, 3);
			cop = l1d_pkg::cop_e'(sel[1:0]);
			sel = $urandom_range(0, 2);
			sz  = 3'd1 << sel[1:0];
			case (sz)
				3'd1:    boff = $urandom_range(0, 3);
				3'd2:    boff = 2 * $urandom_range(0, 1);
				default: boff = 0;
			endcase
			a = ($urandom_range(0, 3) << 4) + ($urandom_range(0, 3) << 2) + boff;
			if (cop == l1d_pkg::COP_RDNC || cop == l1d_pkg::COP_WRNC) begin
				a = a + 32'h8000_0000;
			end else begin
				a = a + 32'h0001_0000 + ($urandom_range(0, 5) << 8);
			end
			access($sformatf("mix %0d", n), cop, a, sz, $urandom());
		end
	endtask

	initial begin
		void'($urandom(32'ha0a));
		clk            = 1'b0;
		rst_n          = 1'b0;
		core_req_val   = 1'b0;
		core_req_addr  = '0;
		core_req_cop   = '0;
		core_req_wdata = '0;
		core_req_size  = 3'd4;
		mem_ack        = 1'b0;
		mem_ack_data   = '0;
		mem_cnt        = 0;
		chk_cnt        = 0;
		err_cnt        = 0;
		for (int s = 0; s < l1d_pkg::SET_NUM; s++) begin
			ref_lru[s]      = 1'b0;
			ref_valid[s][0] = 1'b0;
			ref_valid[s][1] = 1'b0;
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		if (!core_req_ready || core_ack || mem_req_val) begin
			$display("reset state wrong: ready not high or ack or memory request active");
			err_cnt++;
		end
		chk_base = 0;
		err_base = err_cnt;

		access("t1 read miss", l1d_pkg::COP_RD, 32'h0001_0124, 3'd4, '0);
		access("t1 read hit", l1d_pkg::COP_RD, 32'h0001_0124, 3'd4, '0);
		access("t1 read hit other word", l1d_pkg::COP_RD, 32'h0001_012c, 3'd4, '0);
		finish_test("read miss then hit");

		access("t2 write byte", l1d_pkg::COP_WR, 32'h0001_0125, 3'd1, 32'h1122_3344);
		access("t2 write half", l1d_pkg::COP_WR, 32'h0001_0126, 3'd2, 32'h5566_7788);
		access("t2 read merged", l1d_pkg::COP_RD, 32'h0001_0124, 3'd4, '0);
		access("t2 write word", l1d_pkg::COP_WR, 32'h0001_0128, 3'd4, 32'hdead_beef);
		access("t2 read word", l1d_pkg::COP_RD, 32'h0001_0128, 3'd4, '0);
		finish_test("write-through");

		access("t3 write miss", l1d_pkg::COP_WR, 32'h0002_0350, 3'd4, 32'hcafe_f00d);
		access("t3 read after write", l1d_pkg::COP_RD, 32'h0002_0350, 3'd4, '0);
		finish_test("no write allocate");

		access("t4 read A", l1d_pkg::COP_RD, 32'h0003_0090, 3'd4, '0);
		access("t4 read B", l1d_pkg::COP_RD, 32'h0004_0090, 3'd4, '0);
		access("t4 read A again", l1d_pkg::COP_RD, 32'h0003_0090, 3'd4, '0);
		access("t4 read C", l1d_pkg::COP_RD, 32'h0005_0090, 3'd4, '0);
		access("t4 read A kept", l1d_pkg::COP_RD, 32'h0003_0090, 3'd4, '0);
		access("t4 read B evicted", l1d_pkg::COP_RD, 32'h0004_0090, 3'd4, '0);
		finish_test("LRU replacement");

		access("t5 write nc", l1d_pkg::COP_WRNC, 32'h8000_0010, 3'd4, 32'h0bad_c0de);
		access("t5 read nc", l1d_pkg::COP_RDNC, 32'h8000_0010, 3'd4, '0);
		access("t5 read nc again", l1d_pkg::COP_RDNC, 32'h8000_0010, 3'd4, '0);
		access("t5 write nc byte", l1d_pkg::COP_WRNC, 32'h8000_0013, 3'd1, 32'h7700_0000);
		access("t5 read nc merged", l1d_pkg::COP_RDNC, 32'h8000_0010, 3'd4, '0);
		finish_test("uncached access");

		random_mix();
		finish_test("random mix");

		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: sim.f
l1d_pkg.sv
l1d_req_if.sv
l1d_req_decode.sv
l1d_sram.sv
l1d_ctrl.sv
l1d_resp.sv
l1d_top.sv
l1d_props.sv
tb_l1d.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --timing --top-module tb_l1d -Mdir obj_dir -f sim.f
	@out="$$(./obj_dir/Vtb_l1d)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
